// File: all.f
+incdir+hw
hw/mem_pkg.sv
hw/pipe_pkg.sv
hw/mem_stage_buffer.sv
hw/load_align.sv
hw/writeback_unit.sv
hw/backend_top.sv
tests/backend_checker.sv
tests/tb_backend.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_backend, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module tb_backend -Mdir obj_dir -f all.f
	./obj_dir/Vtb_backend +verilator+error+limit+1000 | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_backend.sv
// directed tests for backend_top; one item in flight, read word follows its item by a cycle
`timescale 1ns/1ps
`include "backend_config.svh"

module tb_backend
        import pipe_pkg::*, mem_pkg::*;
();

        logic        i_clk, i_reset, i_data_stall;
        alu_out_s    i_alu;
        logic [31:0] i_dmem_rdata, o_rd_data, o_exc_pc;
        reg_idx_t    i_rd_index;
        logic [3:0]  o_flags;
        logic        o_exc_valid;
        exc_code_e   o_exc_code;
        integer      seed = 32'h2cd9_3c90;
        int          errors = 0, checks = 0, tests = 0, mark = 0;  // mark is errors at test start
        localparam reg_idx_t RAZ = reg_idx_t'(`BACKEND_RAZ_IDX);

        backend_top dut (.*);

        initial
        begin
                i_clk = 1'b0;
                forever #50 i_clk = ~i_clk;     // 100 ns period
        end

        function automatic alu_out_s new_item(input reg_idx_t dst, input logic [31:0] res);
                alu_out_s it;
                it = '0;                        // word size, no load, no exception
                it.dav = 1'b1;
                it.alu_result = res;
                it.destination_index = dst;
                it.mem_srcdest_index = RAZ;
                return it;
        endfunction

        // little-endian lanes, then extension by size
        function automatic logic [31:0] expected_load(input load_size_e size,
                                                      input logic [1:0] off, input logic [31:0] w);
                logic [7:0]  b;
                logic [15:0] h;
                b = 8'(w >> (8 * off));
                h = 16'(w >> (16 * off[1]));    // bit 0 plays no part for halfwords
                case (size)
                LD_HALF_U: return {16'h0, h};
                LD_HALF_S: return {{16{h[15]}}, h};
                LD_BYTE_U: return {24'h0, b};
                LD_BYTE_S: return {{24{b[7]}}, b};
                default:   return w;
                endcase
        endfunction

        task automatic tally(input logic ok, input string msg);
                checks++;
                if (!ok)
                begin
                        errors++;
                        $display("%s", msg);
                end
        endtask

        task automatic check_reg(input reg_idx_t idx, input logic [31:0] exp);
                @(posedge i_clk);
                i_rd_index <= idx;
                @(negedge i_clk);               // combinational read settled
                tally(o_rd_data === exp, $sformatf("FAILED o_rd_data[%0d]: got %h, expected %h",
                                                   idx, o_rd_data, exp));
        endtask

        task automatic check_flags(input logic [3:0] exp);
                @(negedge i_clk);
                tally(o_flags === exp, $sformatf("FAILED o_flags: got %h, expected %h",
                                                 o_flags, exp));
        endtask

        task automatic check_exc(input exc_code_e code, input logic [31:0] pc);
                tally(o_exc_code === code, $sformatf("FAILED o_exc_code: got %h, expected %h",
                                                     o_exc_code, code));
                tally(o_exc_pc === pc, $sformatf("FAILED o_exc_pc: got %h, expected %h",
                                                 o_exc_pc, pc));
        endtask

        // item sampled at the 2nd edge, committed at the 3rd
        task automatic issue_item(input alu_out_s it, input logic [31:0] rdata);
                @(posedge i_clk);
                i_alu <= it;
                @(posedge i_clk);
                i_alu <= '0;
                i_dmem_rdata <= rdata;          // lines up with the buffered item
                @(posedge i_clk);
        endtask

        task automatic apply_reset();
                @(posedge i_clk);
                i_reset <= 1'b1;
                i_alu <= '0;
                repeat (8) @(posedge i_clk);
                i_reset <= 1'b0;
        endtask

        task automatic finish_test(input string name);
                tests++;
                $display("%s: %0d errors", name, errors - mark);
                mark = errors;
        endtask

        task automatic alu_writeback();
                logic [31:0] val;
                for (int i = 0; i < 45; i += 11)        // 0, 11, 22, 33, 44
                begin
                        val = $random(seed);
                        @(posedge i_clk);
                        i_alu <= new_item(reg_idx_t'(i), val);
                        @(posedge i_clk);
                        i_alu <= '0;
                        check_reg(reg_idx_t'(i), val);  // read right after the second edge
                end
                issue_item(new_item(RAZ, 32'hdead_beef), 32'h0);
                check_reg(RAZ, 32'h0);                  // dummy index reads zero
        endtask

        task automatic load_sizes();
                alu_out_s    it;
                logic [31:0] w;
                for (int s = 0; s < 5; s++)
                        for (int off = 0; off < 4; off++)
                        begin
                                w = $random(seed);
                                it = new_item(reg_idx_t'(off == 0 ? 12 : 13), $random(seed));
                                it.mem_srcdest_index = reg_idx_t'(12);  // clash at offset 0
                                it.mem_access.load = 1'b1;
                                it.mem_access.size = load_size_e'(s);
                                it.mem_access.addr_lo = 2'(off);
                                issue_item(it, w);
                                check_reg(reg_idx_t'(12),
                                          expected_load(load_size_e'(s), 2'(off), w));
                                if (off != 0)
                                        check_reg(reg_idx_t'(13), it.alu_result);
                        end
        endtask

        task automatic flag_updates();
                alu_out_s it;
                it = new_item(RAZ, 32'h0);
                check_flags(4'h0);
                it.flags = 4'ha;
                it.flag_update = 1'b1;
                issue_item(it, 32'h0);
                check_flags(4'ha);
                it.flags = 4'h5;
                it.flag_update = 1'b0;                  // flags carried but not committed
                issue_item(it, 32'h0);
                check_flags(4'ha);
                it.flag_update = 1'b1;
                issue_item(it, 32'h0);
                check_flags(4'h5);
        endtask

        task automatic stall_hold();
                logic [31:0] old, val;
                old = $random(seed);
                val = $random(seed);
                issue_item(new_item(reg_idx_t'(20), old), 32'h0);
                @(posedge i_clk);
                i_alu <= new_item(reg_idx_t'(20), val);
                @(posedge i_clk);
                i_alu <= '0;
                i_data_stall <= 1'b1;                   // item now sits in the buffer
                repeat (3) check_reg(reg_idx_t'(20), old);
                @(posedge i_clk);
                i_data_stall <= 1'b0;
                check_reg(reg_idx_t'(20), val);         // written on release
                check_reg(reg_idx_t'(20), val);
        endtask

        task automatic exception_priority();
                // fiq irq abort swi
                logic [3:0]  pairs [4] = '{4'b1100, 4'b0110, 4'b0011, 4'b0001};
                exc_code_e   codes [4] = '{EXC_FIQ, EXC_IRQ, EXC_INSTR_ABORT, EXC_SWI};
                logic [31:0] keep30, keep31;
                alu_out_s    it;
                int          n;
                keep30 = $random(seed);
                keep31 = $random(seed);
                issue_item(new_item(reg_idx_t'(30), keep30), 32'h0);
                issue_item(new_item(reg_idx_t'(31), keep31), 32'h0);
                for (int c = 0; c < 4; c++)
                begin
                        it = new_item(reg_idx_t'(30), $random(seed));
                        it.pc_plus_8 = $random(seed);
                        {it.fiq, it.irq, it.instr_abort, it.swi} = pairs[c];
                        @(posedge i_clk);
                        i_alu <= it;
                        @(posedge i_clk);
                        i_alu <= new_item(reg_idx_t'(31), $random(seed));  // younger item
                        @(negedge i_clk);
                        for (n = 0; n < 8 && !o_exc_valid; n++)
                                @(negedge i_clk);
                        if (o_exc_valid)
                                check_exc(codes[c], it.pc_plus_8);
                        else
                                tally(1'b0, "no exception reported within 8 cycles");
                        @(posedge i_clk);
                        i_alu <= '0;
                        check_reg(reg_idx_t'(30), keep30);
                        check_reg(reg_idx_t'(31), keep31);
                end
        endtask

        task automatic reset_clears();
                apply_reset();
                for (int i = 0; i < `BACKEND_PHY_REGS; i++)
                        check_reg(reg_idx_t'(i), 32'h0);
                check_flags(4'h0);
        endtask

        initial
        begin
                i_reset = 1'b1;
                i_data_stall = 1'b0;
                i_alu = '0;
                i_dmem_rdata = 32'h0;
                i_rd_index = '0;
                apply_reset();
                alu_writeback();
                finish_test("alu writeback");
                load_sizes();
                finish_test("loads");
                flag_updates();
                finish_test("flags");
                stall_hold();
                finish_test("stall");
                exception_priority();
                finish_test("exceptions");
                reset_clears();
                finish_test("reset");
                errors += dut.u_checker.fail_count;     // assertion failures
                $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
                if (errors == 0)
                        $display("Everything OK");
                else
                        $display("Something failed");
                $finish;
        end

endmodule

// File: tests/backend_checker.sv
// assertions for backend_top; reaches into the writeback unit for its register write enables
`timescale 1ns/1ps

module backend_checker
(
        input logic i_clk,
        input logic i_reset,
        input logic i_exc_valid,
        input logic i_clear,            // flush from writeback
        input logic i_buf_dav,          // buffered item valid
        input logic i_alu_wr,
        input logic i_load_wr
);

        int fail_count = 0;             // failed assertions so far

        // excepting item leaves the register file alone
        no_write_on_exc: assert property (@(posedge i_clk) disable iff (i_reset)
                i_exc_valid |-> !(i_alu_wr || i_load_wr))
        else
        begin
                $error("register write in the same cycle as an exception");
                fail_count++;
        end

        // flushed slot comes back empty
        empty_after_clear: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear |=> !i_buf_dav)
        else
        begin
                $error("buffer still valid in the cycle after a clear");
                fail_count++;
        end

        // quiet during reset, first reset edge skipped
        no_exc_in_reset: assert property (@(posedge i_clk)
                (i_reset && $past(i_reset)) |-> !i_exc_valid)
        else
        begin
                $error("exception reported during reset");
                fail_count++;
        end

endmodule

bind backend_top backend_checker u_checker (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_exc_valid (o_exc_valid),
        .i_clear     (wb_clear),
        .i_buf_dav   (mem_q.dav),
        .i_alu_wr    (u_writeback.alu_wr_en),
        .i_load_wr   (u_writeback.load_wr_en)
);

// File: hw/backend_top.sv
// back end of the pipeline; dmem read word must arrive with the buffered item and hold on stall
`timescale 1ns/1ps

module backend_top
        import pipe_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,        // sync, active high
        input  logic        i_data_stall,   // data memory busy

        input  alu_out_s    i_alu,          // item from the ALU stage
        input  logic [31:0] i_dmem_rdata,   // read word, one cycle after issue

        // register read port
        input  reg_idx_t    i_rd_index,
        output logic [31:0] o_rd_data,
        output logic [3:0]  o_flags,

        // exception report
        output logic        o_exc_valid,
        output exc_code_e   o_exc_code,
        output logic [31:0] o_exc_pc
);

        mem_out_s    mem_q;             // buffered item
        logic [31:0] load_value;        // aligned load data
        logic        wb_clear;          // flush from writeback

        // holds the item while memory reads
        mem_stage_buffer u_buffer (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_clear      (wb_clear),
                .i_data_stall (i_data_stall),
                .i_alu        (i_alu),
                .o_mem        (mem_q)
        );

        // read word lines up with mem_q, so its access info drives the lanes
        load_align u_align (
                .i_access     (mem_q.mem_access),
                .i_rdata      (i_dmem_rdata),
                .o_load_value (load_value)
        );

        // register file, flags, exceptions
        writeback_unit u_writeback (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_data_stall (i_data_stall),
                .i_mem        (mem_q),
                .i_load_value (load_value),
                .i_rd_index   (i_rd_index),
                .o_rd_data    (o_rd_data),
                .o_flags      (o_flags),
                .o_clear      (wb_clear),
                .o_exc_valid  (o_exc_valid),
                .o_exc_code   (o_exc_code),
                .o_exc_pc     (o_exc_pc)
        );

endmodule

// File: hw/writeback_unit.sv
// register file with reset, combinational read port; exceptions report code and pc only
`timescale 1ns/1ps
`include "backend_config.svh"

module writeback_unit
        import pipe_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_data_stall,   // no commit while high

        input  mem_out_s    i_mem,          // buffered item
        input  logic [31:0] i_load_value,   // aligned load data for i_mem

        // read port, old value on a same-cycle write
        input  reg_idx_t    i_rd_index,
        output logic [31:0] o_rd_data,
        output logic [3:0]  o_flags,

        // exception report and flush
        output logic        o_clear,
        output logic        o_exc_valid,
        output exc_code_e   o_exc_code,
        output logic [31:0] o_exc_pc
);

        logic [31:0] regs [`BACKEND_PHY_REGS];  // physical register file
        logic [3:0]  flags_q;                   // nzcv

        logic commit;           // valid item on an unstalled cycle
        logic exc_any;          // item carries some exception
        logic alu_wr_en;
        logic load_wr_en;
        logic flag_wr_en;

        // true for an index backed by real storage
        function automatic logic is_real_reg(input reg_idx_t idx);
                return (idx != reg_idx_t'(`BACKEND_RAZ_IDX)) &&
                       (int'(idx) < `BACKEND_PHY_REGS);
        endfunction

        assign commit  = i_mem.dav && !i_data_stall;
        assign exc_any = i_mem.fiq || i_mem.irq || i_mem.instr_abort || i_mem.swi;

        assign o_exc_valid = commit && exc_any;
        assign o_clear     = o_exc_valid;       // flush the buffer this cycle
        assign o_exc_pc    = i_mem.pc_plus_8;

        // fixed priority fiq > irq > abort > swi
        always_comb
        begin
                if (i_mem.fiq)
                        o_exc_code = EXC_FIQ;
                else if (i_mem.irq)
                        o_exc_code = EXC_IRQ;
                else if (i_mem.instr_abort)
                        o_exc_code = EXC_INSTR_ABORT;
                else if (i_mem.swi)
                        o_exc_code = EXC_SWI;
                else
                        o_exc_code = EXC_NONE;
        end

        // an excepting item writes nothing
        assign alu_wr_en  = commit && !exc_any && is_real_reg(i_mem.destination_index);
        assign load_wr_en = commit && !exc_any && i_mem.mem_access.load &&
                            is_real_reg(i_mem.mem_srcdest_index);
        assign flag_wr_en = commit && !exc_any && i_mem.flag_update;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < `BACKEND_PHY_REGS; i++)
                        begin
                                regs[i] <= '0;
                        end
                        flags_q <= '0;
                end
                else
                begin
                        if (alu_wr_en)
                                regs[i_mem.destination_index] <= i_mem.alu_result;
                        if (load_wr_en)         // later assignment, load wins on a tie
                                regs[i_mem.mem_srcdest_index] <= i_load_value;
                        if (flag_wr_en)
                                flags_q <= i_mem.flags;
                end
        end

        // raz and out-of-range indices read zero
        assign o_rd_data = is_real_reg(i_rd_index) ? regs[i_rd_index] : 32'h0;
        assign o_flags   = flags_q;

endmodule

// File: hw/load_align.sv
// little-endian lane select; word loads ignore the low address bits, no rotation
`timescale 1ns/1ps

module load_align
        import mem_pkg::*;
(
        input  access_s     i_access,       // size and byte offset
        input  rdata_u      i_rdata,        // raw word from data memory
        output logic [31:0] o_load_value    // aligned, extended value
);

        logic [15:0] sel_half;  // halfword picked by addr bit 1
        logic [7:0]  sel_byte;  // byte picked by both addr bits

        // lane select through the union views
        assign sel_half = i_rdata.half[i_access.addr_lo[1]];
        assign sel_byte = i_rdata.bytes[i_access.addr_lo];

        // extension by load size
        always_comb
        begin
                case (i_access.size)
                LD_WORD:
                        o_load_value = i_rdata.word;            // whole word
                LD_HALF_U:
                        o_load_value = {16'h0000, sel_half};
                LD_HALF_S:
                        o_load_value = {{16{sel_half[15]}}, sel_half};
                LD_BYTE_U:
                        o_load_value = {24'h000000, sel_byte};
                LD_BYTE_S:
                        o_load_value = {{24{sel_byte[7]}}, sel_byte};
                default:
                        o_load_value = i_rdata.word;            // unused codes
                endcase
        end

        // odd halfword offsets (addr bit 0 set) just use the lane of bit 1
        // alignment faults are not checked here

endmodule

// File: hw/mem_stage_buffer.sv
// one-item register between ALU and writeback; clear wins over stall, stall holds contents
`timescale 1ns/1ps

module mem_stage_buffer
        import pipe_pkg::*;
(
        input  logic     i_clk,
        input  logic     i_reset,        // sync, active high

        // pipeline control
        input  logic     i_clear,        // flush from writeback, same cycle
        input  logic     i_data_stall,   // memory busy, hold everything

        // bundle in from the ALU stage
        input  alu_out_s i_alu,

        // bundle out to writeback and the aligner
        output mem_out_s o_mem
);

        // the data memory spends this cycle on the read,
        // so the item just waits here for one clock

        // flush happens when writeback takes an exception;
        // the incoming item is younger than the excepting one
        // and must not reach writeback

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_mem <= '0;            // dav low, nothing pending
                end
                else if (i_clear)
                begin
                        o_mem <= '0;            // drop the item behind the exception
                end
                else if (i_data_stall)
                begin
                        o_mem <= o_mem;         // hold, read word is also held
                end
                else
                begin
                        o_mem <= i_alu;         // normal advance
                end
        end

        // clear is never high with stall
        // writeback only raises it on an unstalled cycle
        // but the priority order keeps a flush safe anyway

endmodule

// File: hw/pipe_pkg.sv
// stage bundles for the back end; mem_out_s is the registered copy of alu_out_s
`include "backend_config.svh"

package pipe_pkg;

        import mem_pkg::*;

        // physical register index
        typedef logic [`BACKEND_IDX_W-1:0] reg_idx_t;

        // exception codes reported by writeback
        typedef enum logic [2:0] {
                EXC_NONE        = 3'd0,
                EXC_FIQ         = 3'd1,
                EXC_IRQ         = 3'd2,
                EXC_INSTR_ABORT = 3'd3,
                EXC_SWI         = 3'd4
        } exc_code_e;

        // bundle leaving the ALU stage
        typedef struct packed {
                logic        dav;               // item valid
                logic [31:0] alu_result;
                logic [3:0]  flags;             // nzcv
                logic        flag_update;       // commit flags at writeback
                reg_idx_t    destination_index; // alu result target, raz if none
                reg_idx_t    mem_srcdest_index; // load target, raz if none
                logic [31:0] pc_plus_8;         // return address for exceptions
                logic        irq;
                logic        fiq;
                logic        instr_abort;
                logic        swi;
                access_s     mem_access;        // load descriptor for the aligner
        } alu_out_s;

        // registered copy held by the memory-stage buffer
        typedef alu_out_s mem_out_s;

endpackage

// File: hw/mem_pkg.sv
// data memory access types; loads only, little-endian byte order in the read word
package mem_pkg;

        // load width and extension
        typedef enum logic [2:0] {
                LD_WORD   = 3'd0,
                LD_HALF_U = 3'd1,       // zero extend
                LD_HALF_S = 3'd2,       // sign extend
                LD_BYTE_U = 3'd3,
                LD_BYTE_S = 3'd4
        } load_size_e;

        // what the aligner needs to know about an access
        typedef struct packed {
                logic       load;       // item reads data memory
                load_size_e size;
                logic [1:0] addr_lo;    // low address bits, byte lane
        } access_s;

        // read word, seen whole or split into lanes
        typedef union packed {
                logic [31:0]      word;
                logic [1:0][15:0] half;  // half[1] is the upper halfword
                logic [3:0][7:0]  bytes; // bytes[0] is address offset 0
        } rdata_u;

endpackage

// File: hw/backend_config.svh
// sizes for the 46-entry physical register file; index 45 is the reads-as-zero dummy
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// physical register count
// 16 architectural regs plus banked copies and scratch entries
`define BACKEND_PHY_REGS 46

// index width, enough to address every physical register
`define BACKEND_IDX_W 6

// dummy index for "no register"
// writes to it are dropped and reads return zero
// decode points unused destinations and srcdest here
`define BACKEND_RAZ_IDX 45

`endif
